/* verilog/ahb_mem_pkg.sv */
package ahb_mem_pkg;

    // Bus widths, one word each
    localparam int AHB_ADDR_W = 32;                    // Byte address width
    localparam int AHB_DATA_W = 32;                    // Word data width

    // Address-phase group driven by the master
    typedef struct packed {
        logic                  htrans;                 // 1 = active transfer, 0 = idle
        logic                  hwrite;                 // 1 = write, 0 = read
        logic [AHB_ADDR_W-1:0] haddr;                  // Byte address
    } ahb_req_t;

    // Request from an AHB slave to its memory
    typedef struct packed {
        logic                  valid;                  // Request present this cycle
        logic                  rd0_wr1;                // 0 = read, 1 = write
        logic [AHB_ADDR_W-1:0] addr;                   // Byte address, word index in bits 2 and up
        logic [AHB_DATA_W-1:0] wr_data;                // Write word
    } mem_req_t;

    // Response from a memory back to its slave
    typedef struct packed {
        logic                  ready;                  // Memory can accept a request
        logic                  rd_valid;               // Read data returned this cycle
        logic [AHB_DATA_W-1:0] rd_data;                // Read word
    } mem_rsp_t;

endpackage

/* verilog/ahb_slave.sv */
`timescale 1ns/1ps

module ahb_slave #(
    parameter int MEM_AW = 6                                   // Word-address bits of the memory
) (
    input  logic                              i_clk_ahb,       // AHB clock
    input  logic                              i_rstn_ahb,      // Async reset, active low

    input  logic                              i_hselx,         // Region select from decoder
    input  logic                              i_hready,        // Bus ready, fanned back by decoder
    input  ahb_mem_pkg::ahb_req_t             i_ahb_req,       // Address-phase group
    input  logic [ahb_mem_pkg::AHB_DATA_W-1:0] i_hwdata,       // Write data, valid in data phase

    input  ahb_mem_pkg::mem_rsp_t             i_mem_rsp,       // Memory response

    output logic                              o_hreadyout,     // Slave ready toward decoder
    output logic [ahb_mem_pkg::AHB_DATA_W-1:0] o_hrdata,       // Read data toward decoder

    output ahb_mem_pkg::mem_req_t             o_mem_req        // Memory request
);

    // Two-state FSM, either idle or owning a data phase
    typedef enum logic {
        ST_IDLE = 1'b0,                                        // No data phase for this slave
        ST_DATA = 1'b1                                         // Data phase in progress
    } state_t;

    state_t                              state_q;              // Current phase
    logic                                rd_issued_q;          // Read already accepted by memory
    logic                                dp_write_q;           // Write flag of the data phase
    logic [ahb_mem_pkg::AHB_ADDR_W-1:0]  dp_addr_q;            // Address of the data phase

    logic                                addr_phase;           // Accepted address phase for us
    logic                                mem_fire;             // Request accepted by memory
    logic                                in_data;              // Shorthand for the data state

    assign addr_phase = i_hselx && i_hready && i_ahb_req.htrans;   // Selected, bus ready, active
    assign in_data    = (state_q == ST_DATA);
    assign mem_fire   = o_mem_req.valid && i_mem_rsp.ready;    // Handshake with memory

    // Phase tracking and read-issue flag
    always_ff @(posedge i_clk_ahb or negedge i_rstn_ahb) begin
        if (!i_rstn_ahb) begin
            state_q     <= ST_IDLE;                            // No data phase after reset
            rd_issued_q <= 1'b0;
        end else begin
            if (mem_fire && !dp_write_q) begin
                rd_issued_q <= 1'b1;                           // Read sent once per data phase
            end
            if (i_hready) begin                                // Phases only advance on bus ready
                if (addr_phase) begin
                    state_q     <= ST_DATA;                    // Next cycle is our data phase
                    rd_issued_q <= 1'b0;                       // New transfer, new request
                end else begin
                    state_q     <= ST_IDLE;                    // Other slave or idle transfer
                end
            end
        end
    end

    // Address and direction captured at the address phase, held through wait states
    always_ff @(posedge i_clk_ahb) begin
        if (addr_phase) begin
            dp_addr_q  <= i_ahb_req.haddr;
            dp_write_q <= i_ahb_req.hwrite;
        end
    end

    // Memory request, reads go out in the first data cycle only
    always_comb begin
        o_mem_req.valid   = in_data && (dp_write_q || !rd_issued_q);
        o_mem_req.rd0_wr1 = dp_write_q;                        // Direction from address phase
        o_mem_req.addr    = dp_addr_q;
        o_mem_req.wr_data = i_hwdata;                          // Master drives it in data phase
    end

    // Response toward the bus
    always_comb begin
        if (!in_data) begin
            o_hreadyout = 1'b1;                                // Idle slave never stalls
            o_hrdata    = '0;
        end else if (dp_write_q) begin
            o_hreadyout = i_mem_rsp.ready;                     // Write done when memory takes it
            o_hrdata    = '0;                                  // No read data on writes
        end else begin
            o_hreadyout = i_mem_rsp.rd_valid;                  // Stall until the word returns
            o_hrdata    = i_mem_rsp.rd_data;
        end
    end

endmodule

/* verilog/ahb_decoder.sv */
`timescale 1ns/1ps

module ahb_decoder #(
    parameter int REGION_BIT = 12                              // Address bit selecting the region
) (
    input  logic                               i_clk_ahb,      // AHB clock
    input  logic                               i_rstn_ahb,     // Async reset, active low

    input  ahb_mem_pkg::ahb_req_t              i_ahb_req,      // Address-phase group from master

    input  logic                               i_hreadyout0,   // Slave 0 ready
    input  logic                               i_hreadyout1,   // Slave 1 ready
    input  logic [ahb_mem_pkg::AHB_DATA_W-1:0] i_hrdata0,      // Slave 0 read data
    input  logic [ahb_mem_pkg::AHB_DATA_W-1:0] i_hrdata1,      // Slave 1 read data

    output logic                               o_hsel0,        // Select for slave 0
    output logic                               o_hsel1,        // Select for slave 1
    output logic                               o_hready,       // Bus ready to master and slaves
    output logic [ahb_mem_pkg::AHB_DATA_W-1:0] o_hrdata        // Bus read data
);

    logic dp_valid_q;                                          // A transfer is in its data phase
    logic dp_sel1_q;                                           // Data phase owned by slave 1

    // Region decode straight from the address
    assign o_hsel0 = !i_ahb_req.haddr[REGION_BIT];
    assign o_hsel1 = i_ahb_req.haddr[REGION_BIT];

    // Data-phase owner, updated whenever the bus moves on
    always_ff @(posedge i_clk_ahb or negedge i_rstn_ahb) begin
        if (!i_rstn_ahb) begin
            dp_valid_q <= 1'b0;                                // Nothing in flight
            dp_sel1_q  <= 1'b0;
        end else if (o_hready) begin
            dp_valid_q <= i_ahb_req.htrans;                    // Idle transfer leaves no data phase
            dp_sel1_q  <= o_hsel1;
        end
    end

    // Response mux, no added latency
    always_comb begin
        if (!dp_valid_q) begin
            o_hready = 1'b1;                                   // Bus free when nothing in flight
        end else if (dp_sel1_q) begin
            o_hready = i_hreadyout1;
        end else begin
            o_hready = i_hreadyout0;
        end
        o_hrdata = dp_sel1_q ? i_hrdata1 : i_hrdata0;          // Owner's word
    end

endmodule

/* verilog/sram_model.sv */
`timescale 1ns/1ps

module sram_model #(
    parameter int MEM_AW = 6,                                  // Word-address bits, 2**MEM_AW words
    parameter int RD_LAT = 1                                   // Read latency in cycles, at least 1
) (
    input  logic                  i_clk_ahb,                   // AHB clock
    input  logic                  i_rstn_ahb,                  // Async reset, active low

    input  ahb_mem_pkg::mem_req_t i_mem_req,                   // Request from slave
    output ahb_mem_pkg::mem_rsp_t o_mem_rsp                    // Response to slave
);

    localparam int CNT_W = $clog2(RD_LAT + 1);                 // Enough bits to reach RD_LAT
    localparam logic [CNT_W-1:0] LAT_CNT = CNT_W'(RD_LAT);     // Count value at data return

    logic [ahb_mem_pkg::AHB_DATA_W-1:0] mem_q [2**MEM_AW];     // Word array
    logic [ahb_mem_pkg::AHB_DATA_W-1:0] rd_data_q;             // Word captured at read accept

    logic                               busy_q;                // Read in flight
    logic [CNT_W-1:0]                   cnt_q;                 // Cycles since read accept
    logic [MEM_AW-1:0]                  word_idx;              // Word index from byte address
    logic                               accept;                // Valid and ready this cycle
    logic                               rd_done;               // Latency reached

    assign word_idx = i_mem_req.addr[MEM_AW+1:2];              // Upper bits alias
    assign rd_done  = busy_q && (cnt_q == LAT_CNT);
    assign accept   = i_mem_req.valid && o_mem_rsp.ready;

    // Latency counter for reads
    always_ff @(posedge i_clk_ahb or negedge i_rstn_ahb) begin
        if (!i_rstn_ahb) begin
            busy_q <= 1'b0;
            cnt_q  <= '0;
        end else if (accept && !i_mem_req.rd0_wr1) begin
            busy_q <= 1'b1;                                    // Start counting the read
            cnt_q  <= CNT_W'(1);
        end else if (rd_done) begin
            busy_q <= 1'b0;                                    // Word handed over this cycle
            cnt_q  <= '0;
        end else if (busy_q) begin
            cnt_q  <= cnt_q + CNT_W'(1);
        end
    end

    // Array access, write on accept and read captured on accept
    always_ff @(posedge i_clk_ahb) begin
        if (accept) begin
            if (i_mem_req.rd0_wr1) begin
                mem_q[word_idx] <= i_mem_req.wr_data;          // Visible to any later read
            end else begin
                rd_data_q <= mem_q[word_idx];                  // Nothing can write while busy
            end
        end
    end

    // Ready drops for the whole read, back up in the return cycle
    always_comb begin
        o_mem_rsp.ready    = !busy_q || rd_done;
        o_mem_rsp.rd_valid = rd_done;
        o_mem_rsp.rd_data  = rd_data_q;
    end

endmodule

/* verilog/ahb_mem_top.sv */
`timescale 1ns/1ps

module ahb_mem_top #(
    parameter int MEM_AW     = 6,                              // Word-address bits per memory
    parameter int RD_LAT0    = 1,                              // Read latency of region 0
    parameter int RD_LAT1    = 3,                              // Read latency of region 1
    parameter int REGION_BIT = 12                              // Region select bit
) (
    input  logic                               i_clk_ahb,      // AHB clock
    input  logic                               i_rstn_ahb,     // Async reset, active low
    input  ahb_mem_pkg::ahb_req_t              i_ahb_req,      // Address phase from master
    input  logic [ahb_mem_pkg::AHB_DATA_W-1:0] i_hwdata,       // Write data from master
    output logic                               o_hready,       // Bus ready
    output logic [ahb_mem_pkg::AHB_DATA_W-1:0] o_hrdata        // Bus read data
);

    logic                               hsel0, hsel1;          // Region selects
    logic                               hreadyout0, hreadyout1;
    logic [ahb_mem_pkg::AHB_DATA_W-1:0] hrdata0, hrdata1;
    ahb_mem_pkg::mem_req_t              mem_req0, mem_req1;    // Slave to memory
    ahb_mem_pkg::mem_rsp_t              mem_rsp0, mem_rsp1;    // Memory to slave

    ahb_decoder #(.REGION_BIT(REGION_BIT)) decoder_i (
        .i_clk_ahb    (i_clk_ahb),    .i_rstn_ahb   (i_rstn_ahb),
        .i_ahb_req    (i_ahb_req),
        .i_hreadyout0 (hreadyout0),   .i_hreadyout1 (hreadyout1),
        .i_hrdata0    (hrdata0),      .i_hrdata1    (hrdata1),
        .o_hsel0      (hsel0),        .o_hsel1      (hsel1),
        .o_hready     (o_hready),     .o_hrdata     (o_hrdata)
    );

    // Region 0, short latency
    ahb_slave #(.MEM_AW(MEM_AW)) slave0_i (
        .i_clk_ahb   (i_clk_ahb),  .i_rstn_ahb (i_rstn_ahb),
        .i_hselx     (hsel0),      .i_hready   (o_hready),
        .i_ahb_req   (i_ahb_req),  .i_hwdata   (i_hwdata),
        .i_mem_rsp   (mem_rsp0),   .o_hreadyout(hreadyout0),
        .o_hrdata    (hrdata0),    .o_mem_req  (mem_req0)
    );

    sram_model #(.MEM_AW(MEM_AW), .RD_LAT(RD_LAT0)) mem0_i (
        .i_clk_ahb (i_clk_ahb), .i_rstn_ahb (i_rstn_ahb),
        .i_mem_req (mem_req0),  .o_mem_rsp  (mem_rsp0)
    );

    // Region 1, long latency
    ahb_slave #(.MEM_AW(MEM_AW)) slave1_i (
        .i_clk_ahb   (i_clk_ahb),  .i_rstn_ahb (i_rstn_ahb),
        .i_hselx     (hsel1),      .i_hready   (o_hready),
        .i_ahb_req   (i_ahb_req),  .i_hwdata   (i_hwdata),
        .i_mem_rsp   (mem_rsp1),   .o_hreadyout(hreadyout1),
        .o_hrdata    (hrdata1),    .o_mem_req  (mem_req1)
    );

    sram_model #(.MEM_AW(MEM_AW), .RD_LAT(RD_LAT1)) mem1_i (
        .i_clk_ahb (i_clk_ahb), .i_rstn_ahb (i_rstn_ahb),
        .i_mem_req (mem_req1),  .o_mem_rsp  (mem_rsp1)
    );

endmodule

/* dv/tb_ahb_mem.sv */
`timescale 1ns/1ps

module tb_ahb_mem;

    localparam int RD_LAT0   = 1;                              // Region 0 read wait states
    localparam int RD_LAT1   = 3;                              // Region 1 read wait states
    localparam int STALL_MAX = 20;                             // Wait-state limit per data phase
    localparam int N_RANDOM  = 600;                            // Random transfers after directed part

    logic                               clk_ahb;
    logic                               rstn_ahb;
    ahb_mem_pkg::ahb_req_t              req;                   // Address-phase inputs
    logic [ahb_mem_pkg::AHB_DATA_W-1:0] hwdata;
    logic                               hready;
    logic [ahb_mem_pkg::AHB_DATA_W-1:0] hrdata;

    logic [31:0] model0 [int];                                 // Region 0 words by index
    logic [31:0] model1 [int];                                 // Region 1 words by index

    logic        dp_act;                                       // Transfer in data phase
    logic        dp_wr;
    logic        dp_region;
    logic [5:0]  dp_idx;
    logic [31:0] dp_wdata;

    int data_errs;
    int lat_errs;
    int rdy_errs;
    int timeouts;
    int reads_checked;

    ahb_mem_top dut_i (
        .i_clk_ahb  (clk_ahb),
        .i_rstn_ahb (rstn_ahb),
        .i_ahb_req  (req),
        .i_hwdata   (hwdata),
        .o_hready   (hready),
        .o_hrdata   (hrdata)
    );

    initial clk_ahb = 1'b0;
    always #10 clk_ahb = ~clk_ahb;                             // 20 ns period

    // Byte address, region on bit 12, word index on bits 7:2, rest is alias noise
    function automatic logic [31:0] make_addr(input logic region, input logic [5:0] idx,
                                              input logic [31:0] noise);
        logic [31:0] a;
        a       = noise;
        a[12]   = region;
        a[7:2]  = idx;
        a[1:0]  = 2'b00;                                       // Word aligned
        return a;
    endfunction

    task automatic check_ready_high();
        assert (hready === 1'b1) else begin
            rdy_errs++;
            $display("FAILED o_hready: got %h expected %h", hready, 1'b1);
        end
    endtask

    task automatic check_read(input logic [31:0] exp);
        reads_checked++;
        assert (hrdata === exp) else begin
            data_errs++;
            $display("FAILED o_hrdata: got %h expected %h (region %0d index %h)",
                     hrdata, exp, dp_region, dp_idx);
        end
    endtask

    task automatic report_and_finish();
        $display("errors: data %0d, latency %0d, ready %0d, timeout %0d; reads checked %0d",
                 data_errs, lat_errs, rdy_errs, timeouts, reads_checked);
        if (data_errs + lat_errs + rdy_errs + timeouts == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    endtask

    // Called on a falling edge, ends the pending data phase then drives one address phase
    task automatic step(input logic act, input logic wr, input logic region,
                        input logic [5:0] idx, input logic [31:0] noise,
                        input logic [31:0] wdata);
        int lows;
        int exp_lat;
        if (timeouts != 0) begin
            return;                                            // Bus abandoned after a timeout
        end
        lows   = 0;
        hwdata = (dp_act && dp_wr) ? dp_wdata : $urandom;      // Write word in its data cycle
        while (!hready && lows < STALL_MAX) begin              // Wait states, inputs held
            lows++;
            @(negedge clk_ahb);
        end
        assert (lows < STALL_MAX) else begin
            timeouts++;
            $display("Timeout: o_hready stayed low for %0d cycles in a data phase", lows);
        end
        if (timeouts != 0) begin
            return;
        end
        if (dp_act) begin
            exp_lat = dp_wr ? 0 : (dp_region ? RD_LAT1 : RD_LAT0);
            assert (lows == exp_lat) else begin
                lat_errs++;
                $display("FAILED o_hready low cycles: got %h expected %h (region %0d %s)",
                         lows, exp_lat, dp_region, dp_wr ? "write" : "read");
            end
            if (dp_wr && dp_region) begin
                model1[dp_idx] = dp_wdata;
            end else if (dp_wr) begin
                model0[dp_idx] = dp_wdata;
            end else if (dp_region && model1.exists(dp_idx)) begin
                check_read(model1[dp_idx]);
            end else if (!dp_region && model0.exists(dp_idx)) begin
                check_read(model0[dp_idx]);                    // Unwritten words skipped
            end
        end
        req.htrans = act;                                      // Accepted at the next rising edge
        req.hwrite = wr;
        req.haddr  = make_addr(region, idx, noise);
        dp_act     = act;
        dp_wr      = wr;
        dp_region  = region;
        dp_idx     = idx;
        dp_wdata   = wdata;
        @(negedge clk_ahb);
    endtask

    initial begin
        void'($urandom(32'h4273));                             // Single seed for the run
        req           = '0;
        hwdata        = '0;
        rstn_ahb      = 1'b0;
        dp_act        = 1'b0;
        dp_wr         = 1'b0;
        dp_region     = 1'b0;
        dp_idx        = '0;
        dp_wdata      = '0;
        data_errs     = 0;
        lat_errs      = 0;
        rdy_errs      = 0;
        timeouts      = 0;
        reads_checked = 0;
        for (int i = 0; i < 8; i++) begin                      // Bus ready throughout reset
            @(negedge clk_ahb);
            check_ready_high();
        end
        rstn_ahb = 1'b1;
        @(negedge clk_ahb);
        check_ready_high();                                    // First cycle out of reset

        // Write then read back, both regions
        step(1'b1, 1'b1, 1'b0, 6'h05, $urandom, 32'ha5a5_0001);
        step(1'b1, 1'b0, 1'b0, 6'h05, $urandom, 32'h0);
        step(1'b1, 1'b1, 1'b1, 6'h05, $urandom, 32'h5a5a_0002);
        step(1'b1, 1'b0, 1'b1, 6'h05, $urandom, 32'h0);

        // Aliased addresses differ in bits 31:13 and 11:8
        step(1'b1, 1'b1, 1'b1, 6'h2a, 32'h0000_0000, 32'h1111_2222);
        step(1'b1, 1'b0, 1'b1, 6'h2a, 32'hffff_ef00, 32'h0);
        step(1'b1, 1'b1, 1'b1, 6'h2a, 32'h8000_0f00, 32'h3333_4444);
        step(1'b1, 1'b0, 1'b1, 6'h2a, 32'h0000_0000, 32'h0);
        step(1'b1, 1'b1, 1'b0, 6'h2a, 32'h1234_0300, 32'h5555_6666);
        step(1'b1, 1'b0, 1'b0, 6'h2a, 32'h0000_0000, 32'h0);

        // Idle write cycles aimed at the same words, then read back
        step(1'b1, 1'b1, 1'b0, 6'h11, $urandom, 32'hcafe_0011);
        step(1'b1, 1'b1, 1'b1, 6'h11, $urandom, 32'hbeef_0011);
        repeat (5) step(1'b0, 1'b1, 1'($urandom), 6'h11, $urandom, $urandom);
        step(1'b1, 1'b0, 1'b0, 6'h11, $urandom, 32'h0);
        step(1'b1, 1'b0, 1'b1, 6'h11, $urandom, 32'h0);

        // Random back-to-back traffic over both regions
        for (int n = 0; n < N_RANDOM; n++) begin
            if ($urandom_range(0, 3) == 0) begin
                step(1'b0, 1'($urandom), 1'($urandom), 6'($urandom), $urandom, $urandom);
            end else begin
                step(1'b1, 1'($urandom), 1'($urandom), 6'($urandom), $urandom, $urandom);
            end
        end
        step(1'b0, 1'b0, 1'b0, 6'h00, 32'h0, 32'h0);           // Closes the last data phase
        report_and_finish();
    end

endmodule

/* ahb_mem.f */
verilog/ahb_mem_pkg.sv
verilog/ahb_slave.sv
verilog/ahb_decoder.sv
verilog/sram_model.sv
verilog/ahb_mem_top.sv
dv/tb_ahb_mem.sv
